/* all.f */
rtl/elinkPkg.sv
rtl/code8b10bPkg.sv
rtl/elinkPacketGen.sv
rtl/elinkTxFifo.sv
rtl/elinkEnc8b10b.sv
rtl/elinkDec8b10b.sv
rtl/elinkLoopTop.sv
dv/elinkLoop_assertions.sv
dv/tbClockGen.sv
dv/elinkTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the E-link loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module elinkTb -f all.f -o elinkSim

simStatus=0
./obj_dir/elinkSim +verilator+error+limit+1000 > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || [ "$simStatus" -ne 0 ]; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

/* dv/elinkTb.sv */
`timescale 1ns/1ps
module elinkTb import elinkPkg::*; ();

  localparam int phaseCycles = 1500;
  localparam int alignLimit  = 40;
  localparam int testCycles  = 2 * (8 + alignLimit + phaseCycles) + 20;

  logic       getDataTrig;
  logic       arstN;
  logic       rstReq;
  logic       enable;
  logic [1:0] serial;
  logic [7:0] rxByte;
  wordKind    rxKind;
  logic       rxValid;
  logic       aligned;
  logic       codeErr;

  // Reference of the packet rule
  int         expPhase = 0;  // 0 SOP, 1 data, 2 EOP
  int         expLen = 1;
  int         expDone = 0;
  logic [7:0] expByte = 8'h00;
  int         rxCount = 0;
  int         mismatchErrs = 0;
  int         checkErrs = 0;

  tbClockGen clockGen (
    .rstReq      (rstReq),
    .getDataTrig (getDataTrig),
    .arstN       (arstN)
  );

  elinkLoopTop UUT (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .enable      (enable),
    .serial      (serial),
    .rxByte      (rxByte),
    .rxKind      (rxKind),
    .rxValid     (rxValid),
    .aligned     (aligned),
    .codeErr     (codeErr)
  );

  bind elinkLoopTop elinkLoopAssertions loopChk (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .serial      (serial),
    .rxKind      (rxKind),
    .rxValid     (rxValid),
    .aligned     (aligned),
    .codeErr     (codeErr)
  );

  task automatic compareValue(input string name, input logic [7:0] expVal,
                              input logic [7:0] gotVal);
    if (expVal !== gotVal)
    begin
      mismatchErrs++;
      $display("MISMATCH %s expected %h actual %h at %0t", name, expVal, gotVal, $time);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge getDataTrig)
  begin
    if (!arstN)
    begin
      expPhase = 0;
      expLen   = 1;
      expDone  = 0;
      expByte  = 8'h00;  // Generator restarts from byte 0
    end
    else if (rxValid)
    begin
      rxCount++;
      case (expPhase)
        0:
        begin
          compareValue("rxKind", 8'(kindSop), 8'(rxKind));
          compareValue("rxByte", 8'h00, rxByte);
          expPhase = 1;
          expDone  = 0;
        end
        1:
        begin
          compareValue("rxKind", 8'(kindData), 8'(rxKind));
          compareValue("rxByte", expByte, rxByte);
          expByte = expByte + 8'd1;
          expDone++;
          if (expDone == expLen)
            expPhase = 2;
        end
        default:
        begin
          compareValue("rxKind", 8'(kindEop), 8'(rxKind));
          compareValue("rxByte", 8'h00, rxByte);
          expLen   = (expLen == maxPktLen) ? 1 : expLen + 1;
          expPhase = 0;
        end
      endcase
    end
  end

  task automatic waitAligned();
    int waited;
    waited = 0;
    while (!aligned && waited < alignLimit)
    begin
      @(negedge getDataTrig);
      waited++;
    end
    if (!aligned)
    begin
      checkErrs++;
      $display("aligned did not rise within %0d cycles after reset release", alignLimit);
    end
  endtask

  // Random high and low stretches on enable
  task automatic runTraffic(input int cycles);
    int  left;
    int  stretch;
    logic level;
    left = cycles;
    while (left > 0)
    begin
      level   = ($urandom % 4) != 0;
      stretch = level ? 20 + $urandom % 180 : 90 + $urandom % 60;  // Lows outlast a FIFO drain
      if (stretch > left)
        stretch = left;
      @(negedge getDataTrig);
      enable = level;
      repeat (stretch - 1) @(negedge getDataTrig);
      left -= stretch;
    end
    enable = 1'b1;
  endtask

  task automatic runPhase();
    int startCount;
    startCount = rxCount;
    waitAligned();
    runTraffic(phaseCycles);
    if (rxCount == startCount)
    begin
      checkErrs++;
      $display("No words were received during the traffic phase");
    end
    if (!aligned)
    begin
      checkErrs++;
      $display("Alignment was lost during the traffic phase");
    end
  endtask

  initial
  begin
    int assertErrs;
    void'($urandom(32'ha653bb41));
    rstReq = 1'b0;
    enable = 1'b0;
    wait (arstN === 1'b1);
    runPhase();
    // Reset in the middle of traffic
    @(negedge getDataTrig);
    rstReq = 1'b1;
    #1;
    if (aligned !== 1'b0 || rxValid !== 1'b0)
    begin
      checkErrs++;
      $display("Reset did not clear rxValid and aligned at once");
    end
    repeat (4) @(negedge getDataTrig);
    rstReq = 1'b0;
    runPhase();
    @(negedge getDataTrig);
    assertErrs = UUT.loopChk.assertFails;
    $display("Errors: mismatches %0d, checks %0d, assertions %0d",
             mismatchErrs, checkErrs, assertErrs);
    if (mismatchErrs + checkErrs + assertErrs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Watchdog at 1.5 times the expected run length
  initial
  begin
    #(testCycles * 15);
    $display("Watchdog expired after %0d ns, the run did not finish", testCycles * 15);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* dv/tbClockGen.sv */
`timescale 1ns/1ps
module tbClockGen (
  input  logic rstReq,
  output logic getDataTrig,
  output logic arstN
);

  logic porDone = 1'b0;

  // 10 ns period
  always
  begin
    getDataTrig = 1'b0;
    #5;
    getDataTrig = 1'b1;
    #5;
  end

  initial
  begin
    repeat (4) @(posedge getDataTrig);
    @(negedge getDataTrig);
    porDone = 1'b1;  // Released on a falling edge
  end

  assign arstN = porDone && !rstReq;

endmodule

/* dv/elinkLoop_assertions.sv */
`timescale 1ns/1ps
module elinkLoopAssertions import elinkPkg::*, code8b10bPkg::*; (
  input logic       getDataTrig,
  input logic       arstN,
  input logic [1:0] serial,
  input wordKind    rxKind,
  input logic       rxValid,
  input logic       aligned,
  input logic       codeErr
);

  localparam int alignLimit = 40;

  int         assertFails = 0;
  logic [5:0] sinceRst;    // Saturating cycle count after release
  logic [2:0] sinceValid;
  logic       inPkt;       // Between SOP and EOP
  logic [3:0] pktBytes;
  logic [9:0] firstSym;    // Line bits of the first symbol after release

  always_ff @(posedge getDataTrig or negedge arstN)
  begin
    if (!arstN)
    begin
      sinceRst   <= '0;
      sinceValid <= 3'(symCycles);
      inPkt      <= 1'b0;
      pktBytes   <= '0;
      firstSym   <= '0;
    end
    else
    begin
      if (sinceRst != 6'd63)
        sinceRst <= sinceRst + 6'd1;
      if (sinceRst != 6'd0 && sinceRst <= 6'(symCycles))
        firstSym <= {firstSym[7:0], serial[0], serial[1]};  // Lane 0 carries the earlier bit
      if (rxValid)
        sinceValid <= 3'd1;
      else if (sinceValid != 3'(symCycles))
        sinceValid <= sinceValid + 3'd1;
      if (rxValid)
      begin
        case (rxKind)
          kindSop:
          begin
            inPkt    <= 1'b1;
            pktBytes <= '0;
          end
          kindData: pktBytes <= pktBytes + 4'd1;
          default:  inPkt <= 1'b0;
        endcase
      end
    end
  end

  firstComma: assert property (@(posedge getDataTrig) disable iff (!arstN)
    sinceRst == 6'(symCycles + 1) |-> firstSym == commaNeg)
    else begin assertFails++; $error("first symbol after reset is not the RD- comma"); end

  alignInTime: assert property (@(posedge getDataTrig) disable iff (!arstN)
    sinceRst > 6'(alignLimit) |-> aligned)
    else begin assertFails++; $error("aligned low %0d cycles after reset", alignLimit); end

  alignHeld: assert property (@(posedge getDataTrig) disable iff (!arstN)
    aligned |=> aligned)
    else begin assertFails++; $error("aligned dropped while link running"); end

  sopOutsidePkt: assert property (@(posedge getDataTrig) disable iff (!arstN)
    rxValid && rxKind == kindSop |-> !inPkt)
    else begin assertFails++; $error("SOP received inside an open packet"); end

  wordInsidePkt: assert property (@(posedge getDataTrig) disable iff (!arstN)
    rxValid && rxKind != kindSop |-> inPkt)
    else begin assertFails++; $error("data or EOP outside a packet"); end

  dataFits: assert property (@(posedge getDataTrig) disable iff (!arstN)
    rxValid && rxKind == kindData |-> pktBytes < 4'(maxPktLen))
    else begin assertFails++; $error("packet longer than %0d bytes", maxPktLen); end

  eopLength: assert property (@(posedge getDataTrig) disable iff (!arstN)
    rxValid && rxKind == kindEop |-> pktBytes != '0)
    else begin assertFails++; $error("EOP closed an empty packet"); end

  noCodeErr: assert property (@(posedge getDataTrig) disable iff (!arstN)
    !codeErr)
    else begin assertFails++; $error("decoder flagged a code error"); end

  validSpacing: assert property (@(posedge getDataTrig) disable iff (!arstN)
    rxValid |-> sinceValid >= 3'(symCycles))
    else begin assertFails++; $error("rxValid pulses closer than a symbol"); end

endmodule

/* rtl/elinkLoopTop.sv */
`timescale 1ns/1ps
module elinkLoopTop import elinkPkg::*; (
  input  logic       getDataTrig,
  input  logic       arstN,
  input  logic       enable,
  output logic [1:0] serial,
  output logic [7:0] rxByte,
  output wordKind    rxKind,
  output logic       rxValid,
  output logic       aligned,
  output logic       codeErr
);

  logic [linkWordW-1:0] wrWord;
  logic                 wrEn;
  logic                 full;
  logic [linkWordW-1:0] rdWord;
  logic                 rdEn;
  logic                 empty;

  elinkPacketGen packetGen (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .enable      (enable),
    .full        (full),
    .wrWord      (wrWord),
    .wrEn        (wrEn)
  );

  elinkTxFifo txFifo (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .wrWord      (wrWord),
    .wrEn        (wrEn),
    .rdEn        (rdEn),
    .rdWord      (rdWord),
    .full        (full),
    .empty       (empty)
  );

  elinkEnc8b10b enc (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .rdWord      (rdWord),
    .empty       (empty),
    .rdEn        (rdEn),
    .serial      (serial)
  );

  // Loopback on the serial pair
  elinkDec8b10b dec (
    .getDataTrig (getDataTrig),
    .arstN       (arstN),
    .serial      (serial),
    .rxByte      (rxByte),
    .rxKind      (rxKind),
    .rxValid     (rxValid),
    .aligned     (aligned),
    .codeErr     (codeErr)
  );

endmodule

/* rtl/elinkDec8b10b.sv */
`timescale 1ns/1ps
module elinkDec8b10b import elinkPkg::*, code8b10bPkg::*; (
  input  logic       getDataTrig,
  input  logic       arstN,
  input  logic [1:0] serial,
  output logic [7:0] rxByte,
  output wordKind    rxKind,
  output logic       rxValid,
  output logic       aligned,
  output logic       codeErr
);

  alignState  state;
  logic [19:0] hist;     // Oldest bit at the top
  logic [3:0]  lockOff;
  logic [2:0]  symCnt;
  logic        rdDec;
  logic [1:0]  errRun;   // Consecutive bad symbols
  logic        found;
  logic [3:0]  foundOff;
  logic [9:0]  winSel;
  logic        isComma;
  logic        hit6;
  logic        hit4;
  logic        isK;
  logic [4:0]  x;
  logic [2:0]  y;
  logic [7:0]  kByte;
  logic        dispErr;
  logic        rdMid;
  logic        rdNext;
  logic        symErr;
  logic        symTick;

  assign aligned = (state == stLocked);
  assign winSel  = hist[lockOff +: 10];
  assign isComma = (winSel == commaNeg) || (winSel == commaPos);
  assign symTick = (symCnt == 3'(symCycles - 1));

  // Comma search where the lowest offset wins
  always_comb
  begin
    found    = 1'b0;
    foundOff = '0;
    for (int k = 9; k >= 0; k--)
    begin
      if (hist[k +: 10] == commaNeg || hist[k +: 10] == commaPos)
      begin
        found    = 1'b1;
        foundOff = 4'(k);
      end
    end
  end

  // Reverse mapping and disparity checks
  always_comb
  begin
    hit6  = 1'b0;
    hit4  = 1'b0;
    isK   = 1'b0;
    x     = '0;
    y     = '0;
    kByte = kComma;
    for (int i = 0; i < 32; i++)
      if (winSel[9:4] == code6(5'(i), 1'b0) || winSel[9:4] == code6(5'(i), 1'b1))
      begin
        hit6 = 1'b1;
        x    = 5'(i);
      end
    for (int j = 0; j < 8; j++)
      if (winSel[3:0] == code4(3'(j), 1'b0, 1'b0) || winSel[3:0] == code4(3'(j), 1'b1, 1'b0) ||
          winSel[3:0] == code4(3'(j), 1'b0, 1'b1) || winSel[3:0] == code4(3'(j), 1'b1, 1'b1))
      begin
        hit4 = 1'b1;
        y    = 3'(j);
      end
    rdMid   = ($countones(winSel[9:4]) != 3) ? !rdDec : rdDec;
    rdNext  = ($countones(winSel[3:0]) != 2) ? !rdMid : rdMid;
    dispErr = (!rdDec && $countones(winSel[9:4]) == 2) ||
              (rdDec && $countones(winSel[9:4]) == 4) ||
              (!rdMid && $countones(winSel[3:0]) == 1) ||
              (rdMid && $countones(winSel[3:0]) == 3);
    if (winSel == kNeg(kSop) || winSel == ~kNeg(kSop))
      kByte = kSop;
    else if (winSel == kNeg(kEop) || winSel == ~kNeg(kEop))
      kByte = kEop;
    if (winSel == kNeg(kByte) || winSel == ~kNeg(kByte))
    begin
      isK     = 1'b1;
      dispErr = (winSel == kNeg(kByte)) ? rdDec : !rdDec;
      rdNext  = !rdDec;
    end
    symErr = !(isK || (hit6 && hit4)) || dispErr;
  end

  always_ff @(posedge getDataTrig)
  begin
    if (isK)
    begin
      rxByte <= 8'h00;  // Delimiters carry no payload
      rxKind <= (kByte == kSop) ? kindSop : (kByte == kEop) ? kindEop : kindComma;
    end
    else
    begin
      rxByte <= {y, x};
      rxKind <= kindData;
    end
  end

  always_ff @(posedge getDataTrig or negedge arstN)
  begin
    if (!arstN)
    begin
      state   <= stHunt;
      hist    <= '0;
      lockOff <= '0;
      symCnt  <= '0;
      rdDec   <= 1'b0;
      errRun  <= '0;
      rxValid <= 1'b0;
      codeErr <= 1'b0;
    end
    else
    begin
      hist    <= {hist[17:0], serial[0], serial[1]};
      symCnt  <= symTick ? '0 : symCnt + 3'd1;
      rxValid <= 1'b0;
      codeErr <= 1'b0;
      case (state)
        stHunt:
          if (found)
          begin
            lockOff <= foundOff;
            symCnt  <= '0;
            state   <= stCheck;
          end
        stCheck:
          if (symTick)
          begin
            state  <= isComma ? stLocked : stHunt;
            rdDec  <= (winSel == commaNeg);  // Disparity after the comma
            errRun <= '0;
          end
        default:
          if (symTick)
          begin
            rdDec   <= rdNext;
            codeErr <= symErr;
            rxValid <= !symErr && !(isK && kByte == kComma);
            if (!symErr)
              errRun <= '0;
            else if (errRun == 2'd3)
              state <= stHunt;  // Lost lock
            else
              errRun <= errRun + 2'd1;
          end
      endcase
    end
  end

endmodule

/* rtl/elinkEnc8b10b.sv */
`timescale 1ns/1ps
module elinkEnc8b10b import elinkPkg::*, code8b10bPkg::*; (
  input  logic                 getDataTrig,
  input  logic                 arstN,
  input  logic [linkWordW-1:0] rdWord,
  input  logic                 empty,
  output logic                 rdEn,
  output logic [1:0]           serial
);

  logic [2:0] phase;
  logic [2:0] preCnt;   // Preamble commas sent so far
  logic       rd;       // Running disparity, 1 is positive
  logic [9:0] sr;
  logic       takeWord;
  wordKind    kind;
  logic [7:0] dByte;
  logic [5:0] c6;
  logic [3:0] c4;
  logic       rdMid;
  logic       alt;
  logic [9:0] symNext;
  logic       rdNext;

  assign takeWord = (phase == '0) && !empty && (preCnt == 3'(preambleSyms));
  assign rdEn     = takeWord;
  assign serial   = {sr[8], sr[9]};  // Bit a leaves on lane 0

  always_comb
  begin
    kind  = takeWord ? wordKind'(rdWord[linkWordW-1 -: 2]) : kindComma;
    dByte = rdWord[7:0];
    // Data path, 5b/6b then 3b/4b against the mid disparity
    c6    = code6(dByte[4:0], rd);
    rdMid = ($countones(c6) != 3) ? !rd : rd;
    alt   = (dByte[7:5] == 3'd7) &&
            ((!rdMid && (dByte[4:0] == 5'd17 || dByte[4:0] == 5'd18 ||
                         dByte[4:0] == 5'd20)) ||
             (rdMid && (dByte[4:0] == 5'd11 || dByte[4:0] == 5'd13 ||
                        dByte[4:0] == 5'd14)));
    c4    = code4(dByte[7:5], rdMid, alt);
    case (kind)
      kindData:
      begin
        symNext = {c6, c4};
        rdNext  = ($countones(c4) != 2) ? !rdMid : rdMid;
      end
      kindSop:
      begin
        symNext = rd ? ~kNeg(kSop) : kNeg(kSop);
        rdNext  = !rd;  // K28 groups always flip
      end
      kindEop:
      begin
        symNext = rd ? ~kNeg(kEop) : kNeg(kEop);
        rdNext  = !rd;
      end
      default:
      begin
        symNext = rd ? ~kNeg(kComma) : kNeg(kComma);
        rdNext  = !rd;
      end
    endcase
  end

  always_ff @(posedge getDataTrig or negedge arstN)
  begin
    if (!arstN)
    begin
      phase  <= '0;
      preCnt <= '0;
      rd     <= 1'b0;
      sr     <= '0;
    end
    else
    begin
      phase <= (phase == 3'(symCycles - 1)) ? '0 : phase + 3'd1;
      if (phase == '0)
      begin
        sr <= symNext;
        rd <= rdNext;
        if (preCnt != 3'(preambleSyms))
          preCnt <= preCnt + 3'd1;
      end
      else
        sr <= {sr[7:0], 2'b00};
    end
  end

endmodule

/* rtl/elinkTxFifo.sv */
`timescale 1ns/1ps
module elinkTxFifo import elinkPkg::*; (
  input  logic                 getDataTrig,
  input  logic                 arstN,
  input  logic [linkWordW-1:0] wrWord,
  input  logic                 wrEn,
  input  logic                 rdEn,
  output logic [linkWordW-1:0] rdWord,
  output logic                 full,
  output logic                 empty
);

  localparam int ptrW = $clog2(fifoDepth);

  logic [linkWordW-1:0] mem [fifoDepth];
  logic [ptrW-1:0]      wrPtr;
  logic [ptrW-1:0]      rdPtr;
  logic [ptrW:0]        count;

  // Show-ahead, oldest word always on the output
  assign rdWord = mem[rdPtr];
  assign full   = (count == (ptrW+1)'(fifoDepth));
  assign empty  = (count == '0);

  always_ff @(posedge getDataTrig)
  begin
    if (wrEn)
      mem[wrPtr] <= wrWord;
  end

  always_ff @(posedge getDataTrig or negedge arstN)
  begin
    if (!arstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= wrPtr + 1'b1;  // Wraps at depth
      if (rdEn)
        rdPtr <= rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/elinkPacketGen.sv */
`timescale 1ns/1ps
module elinkPacketGen import elinkPkg::*; (
  input  logic                 getDataTrig,
  input  logic                 arstN,
  input  logic                 enable,
  input  logic                 full,
  output logic [linkWordW-1:0] wrWord,
  output logic                 wrEn
);

  typedef enum logic [1:0] {
    genIdle,
    genSop,
    genData,
    genEop
  } genState;

  genState    state;
  logic [3:0] pktLen;   // Data bytes in the current packet
  logic [3:0] dataCnt;  // Data bytes already written
  logic [7:0] byteCnt;

  // Next word is held until the FIFO accepts it
  assign wrEn = enable && !full && (state != genIdle);

  always_comb
  begin
    case (state)
      genData: wrWord = {kindData, byteCnt};
      genEop:  wrWord = {kindEop, 8'h00};
      default: wrWord = {kindSop, 8'h00};
    endcase
  end

  always_ff @(posedge getDataTrig or negedge arstN)
  begin
    if (!arstN)
    begin
      state   <= genIdle;
      pktLen  <= 4'd1;
      dataCnt <= '0;
      byteCnt <= '0;
    end
    else if (state == genIdle)
      state <= genSop;
    else if (wrEn)
    begin
      case (state)
        genSop:
        begin
          dataCnt <= '0;
          state   <= genData;
        end
        genData:
        begin
          byteCnt <= byteCnt + 8'd1;  // Runs on across packets
          dataCnt <= dataCnt + 4'd1;
          if (dataCnt + 4'd1 == pktLen)
            state <= genEop;
        end
        default:
        begin
          pktLen <= (pktLen == 4'(maxPktLen)) ? 4'd1 : pktLen + 4'd1;
          state  <= genSop;
        end
      endcase
    end
  end

endmodule

/* rtl/code8b10bPkg.sv */
package code8b10bPkg;

  // Control bytes
  localparam logic [7:0] kComma = 8'hBC;  // K28.5
  localparam logic [7:0] kSop = 8'hDC;    // K28.6
  localparam logic [7:0] kEop = 8'h7C;    // K28.3

  // Code groups listed abcdei fghj with bit 9 sent first
  localparam logic [9:0] commaNeg = 10'b0011111010;
  localparam logic [9:0] commaPos = 10'b1100000101;

  typedef enum logic [1:0] {
    stHunt,
    stCheck,
    stLocked
  } alignState;

  // 5b/6b RD- column complemented for RD+ when unbalanced or D.07
  function automatic logic [5:0] code6(input logic [4:0] x, input logic rd);
    logic [5:0] c;
    case (x)
      5'd0: c = 6'b100111;
      5'd1: c = 6'b011101;
      5'd2: c = 6'b101101;
      5'd3: c = 6'b110001;
      5'd4: c = 6'b110101;
      5'd5: c = 6'b101001;
      5'd6: c = 6'b011001;
      5'd7: c = 6'b111000;
      5'd8: c = 6'b111001;
      5'd9: c = 6'b100101;
      5'd10: c = 6'b010101;
      5'd11: c = 6'b110100;
      5'd12: c = 6'b001101;
      5'd13: c = 6'b101100;
      5'd14: c = 6'b011100;
      5'd15: c = 6'b010111;
      5'd16: c = 6'b011011;
      5'd17: c = 6'b100011;
      5'd18: c = 6'b010011;
      5'd19: c = 6'b110010;
      5'd20: c = 6'b001011;
      5'd21: c = 6'b101010;
      5'd22: c = 6'b011010;
      5'd23: c = 6'b111010;
      5'd24: c = 6'b110011;
      5'd25: c = 6'b100110;
      5'd26: c = 6'b010110;
      5'd27: c = 6'b110110;
      5'd28: c = 6'b001110;
      5'd29: c = 6'b101110;
      5'd30: c = 6'b011110;
      default: c = 6'b101011;
    endcase
    if (rd && ($countones(c) != 3 || x == 5'd7))
      c = ~c;
    return c;
  endfunction

  // 3b/4b code where alt selects the A7 form of D.x.7
  function automatic logic [3:0] code4(input logic [2:0] y, input logic rd, input logic alt);
    logic [3:0] c;
    case (y)
      3'd0: c = 4'b1011;
      3'd1: c = 4'b1001;
      3'd2: c = 4'b0101;
      3'd3: c = 4'b1100;
      3'd4: c = 4'b1101;
      3'd5: c = 4'b1010;
      3'd6: c = 4'b0110;
      default: c = alt ? 4'b0111 : 4'b1110;
    endcase
    if (rd && (y == 3'd0 || y == 3'd3 || y == 3'd4 || y == 3'd7))
      c = ~c;
    return c;
  endfunction

  // RD- group of the supported K28 characters with RD+ as its complement
  function automatic logic [9:0] kNeg(input logic [7:0] b);
    case (b)
      kSop: return 10'b0011110110;
      kEop: return 10'b0011110011;
      default: return commaNeg;
    endcase
  endfunction

endpackage

/* rtl/elinkPkg.sv */
package elinkPkg;

  // Link word framing
  localparam int linkWordW = 10;  // {kind[1:0], byte[7:0]}
  localparam int fifoDepth = 16;
  localparam int maxPktLen = 8;   // Data bytes in the longest packet

  // Symbol timing at 2 line bits per clock
  localparam int symCycles = 5;
  localparam int preambleSyms = 4;  // Commas sent after reset before any word

  // Delimiter of a link word
  typedef enum logic [1:0] {
    kindData  = 2'd0,
    kindEop   = 2'd1,
    kindSop   = 2'd2,
    kindComma = 2'd3
  } wordKind;

endpackage
